/* rv_core.f */
+incdir+verification
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
verification/tb_rv_core.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_rv_core -f rv_core.f
	./obj_dir/Vtb_rv_core | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/tb_rv_model.svh */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

logic [63:0]	m_x [32];
logic [63:0]	m_pc;
logic [63:0]	m_mem [DATA_WORDS];

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
	return {imm, rd, op};
endfunction

function automatic logic [63:0] alu(input logic [2:0] f3, input logic alt,
		input logic [63:0] a, input logic [63:0] b);
	case (f3)
	3'd0:	return alt ? a - b : a + b;
	3'd1:	return a << b[5:0];
	3'd2:	return {63'd0, $signed(a) < $signed(b)};
	3'd3:	return {63'd0, a < b};
	3'd4:	return a ^ b;
	3'd5: begin
		if (alt)
			return $signed(a) >>> b[5:0];
		return a >> b[5:0];
	end
	3'd6:	return a | b;
	default:	return a & b;
	endcase
endfunction

// One instruction of the ISA, reports the store it makes
task automatic model_step(input logic [31:0] in, output logic st, output logic [31:0] st_adr,
		output logic [7:0] st_sel, output logic [63:0] st_dat);
	logic [63:0]	a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [63:0]	res, npc, ea, d;
	logic [31:0]	w;
	logic		wr, cond;
	a = m_x[in[19:15]];
	b = m_x[in[24:20]];
	imm_i = {{52{in[31]}}, in[31:20]};
	imm_s = {{52{in[31]}}, in[31:25], in[11:7]};
	imm_b = {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
	imm_u = {{32{in[31]}}, in[31:12], 12'h000};
	imm_j = {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
	res = '0;
	wr = 1'b0;
	npc = m_pc + 64'd4;
	st = 1'b0;
	st_adr = '0;
	st_sel = '0;
	st_dat = '0;
	case (in[6:0])
	7'h37: begin
		res = imm_u;
		wr = 1'b1;
	end
	7'h17: begin
		res = m_pc + imm_u;
		wr = 1'b1;
	end
	7'h6f: begin
		res = m_pc + 64'd4;
		wr = 1'b1;
		npc = m_pc + imm_j;
	end
	7'h67: begin
		res = m_pc + 64'd4;
		wr = 1'b1;
		npc = a + imm_i;
	end
	7'h63: begin
		case (in[14:12])
		3'd0:	cond = a == b;
		3'd1:	cond = a != b;
		3'd4:	cond = $signed(a) < $signed(b);
		3'd5:	cond = $signed(a) >= $signed(b);
		3'd6:	cond = a < b;
		3'd7:	cond = a >= b;
		default:	cond = 1'b0;
		endcase
		if (cond)
			npc = m_pc + imm_b;
	end
	7'h13: begin
		res = alu(in[14:12], in[14:12] == 3'd5 && in[30], a, imm_i);
		wr = 1'b1;
	end
	7'h33: begin
		res = alu(in[14:12], in[30], a, b);
		wr = 1'b1;
	end
	7'h03: begin
		ea = a + imm_i;
		d = m_mem[ea[7:3]];
		w = ea[2] ? d[63:32] : d[31:0];
		if (in[14:12] == 3'd3)
			res = d;
		else if (in[14:12] == 3'd6)
			res = {32'd0, w};
		else
			res = {{32{w[31]}}, w};
		wr = 1'b1;
	end
	7'h23: begin
		ea = a + imm_s;
		st = 1'b1;
		st_adr = {ea[31:3], 3'b000};
		st_dat = (in[14:12] == 3'd3) ? b : {2{b[31:0]}};
		if (in[14:12] == 3'd3) begin
			st_sel = 8'hff;
			m_mem[ea[7:3]] = b;
		end else if (ea[2]) begin
			st_sel = 8'hf0;
			m_mem[ea[7:3]][63:32] = b[31:0];
		end else begin
			st_sel = 8'h0f;
			m_mem[ea[7:3]][31:0] = b[31:0];
		end
	end
	default: ;	// Unknown opcode only moves on
	endcase
	if (wr && in[11:7] != 5'd0)
		m_x[in[11:7]] = res;
	m_pc = npc;
endtask

`endif

/* verification/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core;

	localparam logic [63:0] RESET_PC = 64'h0000_0000_8000_0000;
	localparam logic [31:0] DATA_BASE = 32'h0001_0000;
	localparam int DATA_WORDS = 32;
	localparam int PROG_LEN = 200;
	localparam int MAX_CYCLES = PROG_LEN * 16;

	logic		CLK = 1'b0;
	logic		RSTn = 1'b0;
	logic		ibus_cyc;
	logic		ibus_stb;
	logic [31:0]	ibus_adr;
	logic [31:0]	ibus_dat;
	logic		ibus_ack;
	logic		dbus_cyc;
	logic		dbus_stb;
	logic		dbus_we;
	logic [31:0]	dbus_adr;
	logic [7:0]	dbus_sel;
	logic [63:0]	dbus_wdat;
	logic [63:0]	dbus_rdat;
	logic		dbus_ack;

	logic [31:0]	prog [PROG_LEN];
	logic [63:0]	mem [DATA_WORDS];	// Data slave contents
	logic [31:0]	rng;
	logic [31:0]	exp_pc [$];
	logic [31:0]	exp_sadr [$];
	logic [7:0]	exp_ssel [$];
	logic [63:0]	exp_sdat [$];
	int		exp_loads;
	int		fetch_n;
	int		store_n;
	int		load_n;
	int		cycles;
	logic		i_pend;
	int		i_wait;
	logic [31:0]	i_adr;
	logic		d_pend;
	int		d_wait;
	logic [31:0]	d_adr;
	logic		d_we;
	logic [7:0]	d_sel;
	logic [63:0]	d_dat;

	`include "tb_rv_model.svh"

	rv_core #(
		.RESET_PC	(RESET_PC)
	) u_dut (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.ibus_cyc_o	(ibus_cyc),
		.ibus_stb_o	(ibus_stb),
		.ibus_adr_o	(ibus_adr),
		.ibus_dat_i	(ibus_dat),
		.ibus_ack_i	(ibus_ack),
		.dbus_cyc_o	(dbus_cyc),
		.dbus_stb_o	(dbus_stb),
		.dbus_we_o	(dbus_we),
		.dbus_adr_o	(dbus_adr),
		.dbus_sel_o	(dbus_sel),
		.dbus_dat_o	(dbus_wdat),
		.dbus_dat_i	(dbus_rdat),
		.dbus_ack_i	(dbus_ack)
	);

	always #20 CLK = ~CLK;

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [63:0] fill_word(input logic [31:0] adr);
		return {~adr, adr * 32'h9e37_79b9};
	endfunction

	function automatic logic [63:0] lane_mask(input logic [7:0] sel);
		logic [63:0] m;
		for (int b = 0; b < 8; b++)
			m[b*8 +: 8] = {8{sel[b]}};
		return m;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare(input string test, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act)
			abort_run($sformatf("Fail %s expected %h actual %h", test, exp, act));
	endtask

	task automatic build_program();
		logic [31:0]	r;
		logic [31:0]	r2;
		logic [4:0]	rd;
		logic [2:0]	f3;
		logic [11:0]	imm;
		int		t;
		prog[0] = enc_u(DATA_BASE[31:12], 5'd31, 7'h37);	// Data pointer
		prog[1] = enc_u(20'h00000, 5'd30, 7'h17);		// Code pointer for JALR
		for (int i = 2; i < PROG_LEN - 1; i++) begin
			r = next_random();
			r2 = next_random();
			rd = 5'(r[15:8] % 30);	// Never x30 or x31
			f3 = r[28:26];
			t = i + 2 + int'(r[30:29]);
			if (t > PROG_LEN - 1)
				t = PROG_LEN - 1;
			case (r[7:0] % 10)
			0, 1, 2:	prog[i] = enc_r((f3 == 3'd0 || f3 == 3'd5) && r2[0] ? 7'h20 : 7'h00,
					r[25:21], r[20:16], f3, rd);
			3, 4: begin
				imm = r2[11:0];
				if (f3 == 3'd1)
					imm = {6'd0, r2[5:0]};
				else if (f3 == 3'd5)
					imm = {1'b0, r2[6], 4'd0, r2[5:0]};	// SRAI when bit 10 set
				prog[i] = enc_i(imm, r[20:16], f3, rd, 7'h13);
			end
			5:	prog[i] = enc_u(r2[31:12], rd, r2[0] ? 7'h37 : 7'h17);
			6:	prog[i] = enc_b(13'((t - i) * 4), r[25:21], r[20:16],
					(f3 == 3'd2 || f3 == 3'd3) ? 3'd0 : f3);
			7: begin
				if (r2[0])
					prog[i] = enc_j(21'((t - i) * 4), rd);
				else
					prog[i] = enc_i(12'((t - 1) * 4), 5'd30, 3'd0, rd, 7'h67);	// x30 is PC of prog[1]
			end
			8: begin
				if (r2[1:0] == 2'd0)
					prog[i] = enc_i({4'd0, r2[9:5], 3'b000}, 5'd31, 3'd3, rd, 7'h03);
				else
					prog[i] = enc_i({4'd0, r2[9:4], 2'b00}, 5'd31,
						r2[1:0] == 2'd1 ? 3'd2 : 3'd6, rd, 7'h03);
			end
			default: begin
				if (r2[0])
					prog[i] = enc_s({4'd0, r2[9:5], 3'b000}, r[25:21], 5'd31, 3'd3);
				else
					prog[i] = enc_s({4'd0, r2[9:4], 2'b00}, r[25:21], 5'd31, 3'd2);
			end
			endcase
		end
		prog[PROG_LEN-1] = enc_j(21'd0, 5'd0);	// Final loop
	endtask

	task automatic run_model();
		int		idx;
		logic		st;
		logic [31:0]	sa;
		logic [7:0]	ss;
		logic [63:0]	sd;
		for (int k = 0; k < 32; k++)
			m_x[k] = '0;
		m_pc = RESET_PC;
		for (int n = 0; n < 2 * PROG_LEN; n++) begin
			exp_pc.push_back(m_pc[31:0]);
			idx = int'((m_pc - RESET_PC) >> 2);
			if (idx == PROG_LEN - 1)
				return;
			if (prog[idx][6:0] == 7'h03)
				exp_loads++;
			model_step(prog[idx], st, sa, ss, sd);
			if (st) begin
				exp_sadr.push_back(sa);
				exp_ssel.push_back(ss);
				exp_sdat.push_back(sd);
			end
		end
		abort_run("The model never reached the final loop of the program");
	endtask

	task automatic finish_run();
		compare("load count", 64'(exp_loads), 64'(load_n));
		if (store_n == exp_sadr.size()) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			abort_run($sformatf("Fail store count expected %0d actual %0d",
				exp_sadr.size(), store_n));
		end
	endtask

	task automatic check_store();
		logic [63:0] mask;
		mask = lane_mask(dbus_sel);
		if (store_n >= exp_sadr.size()) begin
			abort_run("The core issued more stores than the model predicts");
		end else begin
			compare("store address", 64'(exp_sadr[store_n]), 64'(dbus_adr));
			compare("store sel", 64'(exp_ssel[store_n]), 64'(dbus_sel));
			compare("store data", exp_sdat[store_n] & mask, dbus_wdat & mask);
			mem[dbus_adr[7:3]] = (mem[dbus_adr[7:3]] & ~mask) | (dbus_wdat & mask);
			store_n++;
		end
	endtask

	task automatic serve_dbus();
		compare("dbus cyc", 64'(dbus_stb), 64'(dbus_cyc));
		if (dbus_ack) begin
			dbus_ack = 1'b0;
			d_pend = 1'b0;
		end else if (dbus_stb) begin
			if (!d_pend) begin
				d_pend = 1'b1;
				d_wait = int'(next_random() % 4);
				d_adr = dbus_adr;
				d_we = dbus_we;
				d_sel = dbus_sel;
				d_dat = dbus_wdat;
				if (dbus_adr[31:8] != DATA_BASE[31:8])
					abort_run($sformatf("Data access at %h is outside the data region",
						dbus_adr));
				else if (dbus_we)
					check_store();
				else if (load_n >= exp_loads)
					abort_run("The core issued more loads than the model predicts");
				else
					load_n++;
			end
			compare("dbus adr stable", 64'(d_adr), 64'(dbus_adr));
			compare("dbus we stable", 64'(d_we), 64'(dbus_we));
			compare("dbus sel stable", 64'(d_sel), 64'(dbus_sel));
			compare("dbus data stable", d_dat, dbus_wdat);
			if (d_wait == 0) begin
				dbus_ack = 1'b1;
				dbus_rdat = mem[dbus_adr[7:3]];
			end else begin
				d_wait--;
			end
		end
	endtask

	task automatic serve_ibus();
		compare("ibus cyc", 64'(ibus_stb), 64'(ibus_cyc));
		if (ibus_ack) begin
			ibus_ack = 1'b0;
			i_pend = 1'b0;
		end else if (ibus_stb && !i_pend && fetch_n == exp_pc.size() - 1) begin
			compare("fetch address", 64'(exp_pc[fetch_n]), 64'(ibus_adr));
			finish_run();
		end else if (ibus_stb) begin
			if (!i_pend) begin
				i_pend = 1'b1;
				i_wait = int'(next_random() % 4);
				i_adr = ibus_adr;
				compare("fetch address", 64'(exp_pc[fetch_n]), 64'(ibus_adr));
				fetch_n++;
			end
			compare("ibus adr stable", 64'(i_adr), 64'(ibus_adr));
			if (i_wait == 0) begin
				ibus_ack = 1'b1;
				ibus_dat = prog[int'((ibus_adr - RESET_PC[31:0]) >> 2)];
			end else begin
				i_wait--;
			end
		end
	endtask

	// Both slaves share one random stream
	always @(negedge CLK) begin
		if (RSTn) begin
			serve_dbus();
			serve_ibus();
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > MAX_CYCLES)
			abort_run("Timeout: the core did not reach the final loop in time");
	end

	initial begin
		ibus_dat = '0;
		ibus_ack = 1'b0;
		dbus_rdat = '0;
		dbus_ack = 1'b0;
		rng = 32'd41;
		i_pend = 1'b0;
		d_pend = 1'b0;
		exp_loads = 0;
		fetch_n = 0;
		store_n = 0;
		load_n = 0;
		cycles = 0;
		build_program();
		for (int w = 0; w < DATA_WORDS; w++) begin
			mem[w] = fill_word(DATA_BASE + 32'(w * 8));
			m_mem[w] = mem[w];
		end
		run_model();
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RSTn = 1'b1;
	end

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/100ps

module rv_core #(
	parameter rv_pkg::xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
	input  logic			CLK,
	input  logic			RSTn,

	output logic			ibus_cyc_o,
	output logic			ibus_stb_o,
	output rv_pkg::bus_addr_t	ibus_adr_o,
	input  rv_pkg::inst_t		ibus_dat_i,
	input  logic			ibus_ack_i,

	output logic			dbus_cyc_o,
	output logic			dbus_stb_o,
	output logic			dbus_we_o,
	output rv_pkg::bus_addr_t	dbus_adr_o,
	output rv_pkg::wb_sel_t		dbus_sel_o,
	output rv_pkg::xlen_t		dbus_dat_o,
	input  rv_pkg::xlen_t		dbus_dat_i,
	input  logic			dbus_ack_i
);
	import rv_pkg::*;

	inst_t		inst;
	xlen_t		pc;
	logic		inst_valid;
	xlen_t		next_pc;
	logic		next_pc_valid;

	reg_idx_t	rs1_idx;
	reg_idx_t	rs2_idx;
	xlen_t		rs1_data;
	xlen_t		rs2_data;
	logic		rd_we;
	reg_idx_t	rd_idx;
	xlen_t		rd_data;

	logic		lsu_req;
	logic		lsu_we;
	mem_size_e	lsu_size;
	logic		lsu_unsigned;
	xlen_t		lsu_addr;
	xlen_t		lsu_wdata;
	logic		lsu_done;
	xlen_t		lsu_rdata;

	rv_fetch #(
		.RESET_PC	(RESET_PC)
	) u_fetch (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.next_pc_i	(next_pc),
		.next_pc_valid_i	(next_pc_valid),
		.inst_o		(inst),
		.pc_o		(pc),
		.inst_valid_o	(inst_valid),
		.ibus_cyc_o	(ibus_cyc_o),
		.ibus_stb_o	(ibus_stb_o),
		.ibus_adr_o	(ibus_adr_o),
		.ibus_dat_i	(ibus_dat_i),
		.ibus_ack_i	(ibus_ack_i)
	);

	rv_regfile u_regfile (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.rs1_idx_i	(rs1_idx),
		.rs2_idx_i	(rs2_idx),
		.rs1_data_o	(rs1_data),
		.rs2_data_o	(rs2_data),
		.we_i		(rd_we),
		.rd_idx_i	(rd_idx),
		.rd_data_i	(rd_data)
	);

	rv_execute u_execute (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.inst_i		(inst),
		.pc_i		(pc),
		.inst_valid_i	(inst_valid),
		.next_pc_o	(next_pc),
		.next_pc_valid_o	(next_pc_valid),
		.rs1_idx_o	(rs1_idx),
		.rs2_idx_o	(rs2_idx),
		.rs1_data_i	(rs1_data),
		.rs2_data_i	(rs2_data),
		.rd_we_o	(rd_we),
		.rd_idx_o	(rd_idx),
		.rd_data_o	(rd_data),
		.lsu_req_o	(lsu_req),
		.lsu_we_o	(lsu_we),
		.lsu_size_o	(lsu_size),
		.lsu_unsigned_o	(lsu_unsigned),
		.lsu_addr_o	(lsu_addr),
		.lsu_wdata_o	(lsu_wdata),
		.lsu_done_i	(lsu_done),
		.lsu_rdata_i	(lsu_rdata)
	);

	rv_lsu u_lsu (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.req_i		(lsu_req),
		.we_i		(lsu_we),
		.size_i		(lsu_size),
		.unsigned_i	(lsu_unsigned),
		.addr_i		(lsu_addr),
		.wdata_i	(lsu_wdata),
		.done_o		(lsu_done),
		.rdata_o	(lsu_rdata),
		.dbus_cyc_o	(dbus_cyc_o),
		.dbus_stb_o	(dbus_stb_o),
		.dbus_we_o	(dbus_we_o),
		.dbus_adr_o	(dbus_adr_o),
		.dbus_sel_o	(dbus_sel_o),
		.dbus_dat_o	(dbus_dat_o),
		.dbus_dat_i	(dbus_dat_i),
		.dbus_ack_i	(dbus_ack_i)
	);

endmodule

/* hdl/rv_lsu.sv */
`timescale 1ns/100ps

module rv_lsu (
	input  logic			CLK,
	input  logic			RSTn,
	input  logic			req_i,
	input  logic			we_i,
	input  rv_pkg::mem_size_e	size_i,
	input  logic			unsigned_i,
	input  rv_pkg::xlen_t		addr_i,
	input  rv_pkg::xlen_t		wdata_i,
	output logic			done_o,
	output rv_pkg::xlen_t		rdata_o,
	output logic			dbus_cyc_o,
	output logic			dbus_stb_o,
	output logic			dbus_we_o,
	output rv_pkg::bus_addr_t	dbus_adr_o,
	output rv_pkg::wb_sel_t		dbus_sel_o,
	output rv_pkg::xlen_t		dbus_dat_o,
	input  rv_pkg::xlen_t		dbus_dat_i,
	input  logic			dbus_ack_i
);
	import rv_pkg::*;

	mem_size_e	size_q;
	logic		unsigned_q;
	logic		lane_q;		// Upper word lane
	logic [31:0]	word;
	logic		ack;

	assign ack  = dbus_stb_o && dbus_ack_i;
	assign word = lane_q ? dbus_dat_i[63:32] : dbus_dat_i[31:0];

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			dbus_cyc_o <= 1'b0;
			dbus_stb_o <= 1'b0;
			dbus_we_o  <= 1'b0;
			done_o     <= 1'b0;
		end else begin
			done_o <= ack;
			if (req_i) begin
				dbus_cyc_o <= 1'b1;
				dbus_stb_o <= 1'b1;
				dbus_we_o  <= we_i;
			end else if (ack) begin
				dbus_cyc_o <= 1'b0;
				dbus_stb_o <= 1'b0;
				dbus_we_o  <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (req_i) begin
			size_q     <= size_i;
			unsigned_q <= unsigned_i;
			lane_q     <= addr_i[2];
			dbus_adr_o <= {addr_i[31:3], 3'b000};
			if (size_i == DOUBLE) begin
				dbus_sel_o <= 8'hff;
				dbus_dat_o <= wdata_i;
			end else begin
				dbus_sel_o <= addr_i[2] ? 8'hf0 : 8'h0f;
				dbus_dat_o <= {2{wdata_i[31:0]}};	// Same word on both lanes
			end
		end
		if (ack) begin
			if (size_q == DOUBLE)
				rdata_o <= dbus_dat_i;
			else if (unsigned_q)
				rdata_o <= {32'd0, word};
			else
				rdata_o <= {{32{word[31]}}, word};
		end
	end

	assert property (@(posedge CLK) disable iff (!RSTn)
		req_i |-> addr_i[1:0] == 2'b00 && (size_i == WORD || !addr_i[2]));

endmodule

/* hdl/rv_execute.sv */
`timescale 1ns/100ps

module rv_execute (
	input  logic			CLK,
	input  logic			RSTn,
	input  rv_pkg::inst_t		inst_i,
	input  rv_pkg::xlen_t		pc_i,
	input  logic			inst_valid_i,
	output rv_pkg::xlen_t		next_pc_o,
	output logic			next_pc_valid_o,
	output rv_pkg::reg_idx_t	rs1_idx_o,
	output rv_pkg::reg_idx_t	rs2_idx_o,
	input  rv_pkg::xlen_t		rs1_data_i,
	input  rv_pkg::xlen_t		rs2_data_i,
	output logic			rd_we_o,
	output rv_pkg::reg_idx_t	rd_idx_o,
	output rv_pkg::xlen_t		rd_data_o,
	output logic			lsu_req_o,
	output logic			lsu_we_o,
	output rv_pkg::mem_size_e	lsu_size_o,
	output logic			lsu_unsigned_o,
	output rv_pkg::xlen_t		lsu_addr_o,
	output rv_pkg::xlen_t		lsu_wdata_o,
	input  logic			lsu_done_i,
	input  rv_pkg::xlen_t		lsu_rdata_i
);
	import rv_pkg::*;

	opcode_e	opcode;
	logic [2:0]	funct3;
	logic [6:0]	funct7;
	xlen_t		imm_i;
	xlen_t		imm_s;
	xlen_t		imm_b;
	xlen_t		imm_u;
	xlen_t		imm_j;
	xlen_t		op_b;
	xlen_t		alu_res;
	logic		alu_ok;
	logic		take;
	xlen_t		result;
	logic		wr_en;
	logic		is_load;
	logic		is_store;
	logic		is_mem;
	exec_state_e	state_q;
	logic		mem_fin_q;	// Memory access just finished

	assign opcode    = opcode_e'(inst_i[6:0]);
	assign funct3    = inst_i[14:12];
	assign funct7    = inst_i[31:25];
	assign rd_idx_o  = inst_i[11:7];
	assign rs1_idx_o = inst_i[19:15];
	assign rs2_idx_o = inst_i[24:20];

	assign imm_i = {{XLEN-12{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{XLEN-12{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{XLEN-13{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
			inst_i[11:8], 1'b0};
	assign imm_u = {{XLEN-32{inst_i[31]}}, inst_i[31:12], 12'h000};
	assign imm_j = {{XLEN-21{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
			inst_i[30:21], 1'b0};

	// LW, LD and LWU; SW and SD
	assign is_load  = opcode == LOAD && (funct3 == 3'b010 || funct3 == 3'b011
			|| funct3 == 3'b110);
	assign is_store = opcode == STORE && (funct3 == 3'b010 || funct3 == 3'b011);
	assign is_mem   = is_load || is_store;

	always_comb begin
		op_b = (opcode == OP) ? rs2_data_i : imm_i;
		case (funct3)
		3'b000:	alu_res = (opcode == OP && funct7[5]) ? rs1_data_i - op_b
				: rs1_data_i + op_b;
		3'b001:	alu_res = rs1_data_i << op_b[5:0];
		3'b010:	alu_res = {{XLEN-1{1'b0}}, $signed(rs1_data_i) < $signed(op_b)};
		3'b011:	alu_res = {{XLEN-1{1'b0}}, rs1_data_i < op_b};
		3'b100:	alu_res = rs1_data_i ^ op_b;
		3'b101: begin
			if (funct7[5])
				alu_res = $signed(rs1_data_i) >>> op_b[5:0];
			else
				alu_res = rs1_data_i >> op_b[5:0];
		end
		3'b110:	alu_res = rs1_data_i | op_b;
		default:	alu_res = rs1_data_i & op_b;
		endcase

		// Immediate shifts keep shamt[5] in funct7[0]
		if (opcode == OP)
			alu_ok = funct7 == 7'b0000000
				|| (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
		else if (funct3 == 3'b001)
			alu_ok = funct7[6:1] == 6'b000000;
		else if (funct3 == 3'b101)
			alu_ok = funct7[6:1] == 6'b000000 || funct7[6:1] == 6'b010000;
		else
			alu_ok = 1'b1;
	end

	always_comb begin
		case (funct3)
		3'b000:	take = rs1_data_i == rs2_data_i;
		3'b001:	take = rs1_data_i != rs2_data_i;
		3'b100:	take = $signed(rs1_data_i) < $signed(rs2_data_i);
		3'b101:	take = $signed(rs1_data_i) >= $signed(rs2_data_i);
		3'b110:	take = rs1_data_i < rs2_data_i;
		3'b111:	take = rs1_data_i >= rs2_data_i;
		default:	take = 1'b0;
		endcase
	end

	always_comb begin
		result    = alu_res;
		wr_en     = 1'b0;
		next_pc_o = pc_i + 64'd4;	// Also for unknown opcodes
		case (opcode)
		OP_IMM, OP:	wr_en = alu_ok;
		LUI: begin
			result = imm_u;
			wr_en  = 1'b1;
		end
		AUIPC: begin
			result = pc_i + imm_u;
			wr_en  = 1'b1;
		end
		JAL: begin
			result    = pc_i + 64'd4;
			wr_en     = 1'b1;
			next_pc_o = pc_i + imm_j;
		end
		JALR: begin
			if (funct3 == 3'b000) begin
				result    = pc_i + 64'd4;
				wr_en     = 1'b1;
				next_pc_o = rs1_data_i + imm_i;	// Bit 0 kept
			end
		end
		BRANCH: begin
			if (take)
				next_pc_o = pc_i + imm_b;
		end
		default: ;
		endcase
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			state_q   <= IDLE;
			mem_fin_q <= 1'b0;
		end else begin
			mem_fin_q <= (state_q == MEM) && lsu_done_i;
			case (state_q)
			IDLE, WAIT_FETCH: begin
				if (inst_valid_i)
					state_q <= EXEC;
			end
			EXEC:	state_q <= is_mem ? MEM : WAIT_FETCH;
			MEM: begin
				if (lsu_done_i)
					state_q <= WAIT_FETCH;
			end
			default:	state_q <= IDLE;
			endcase
		end
	end

	assign lsu_req_o      = (state_q == EXEC) && is_mem;
	assign lsu_we_o       = is_store;
	assign lsu_size_o     = funct3[0] ? DOUBLE : WORD;
	assign lsu_unsigned_o = funct3[2];
	assign lsu_addr_o     = rs1_data_i + (is_store ? imm_s : imm_i);
	assign lsu_wdata_o    = rs2_data_i;

	// Instruction word is still held by fetch during MEM
	assign rd_we_o         = ((state_q == EXEC) && wr_en) || (mem_fin_q && is_load);
	assign rd_data_o       = mem_fin_q ? lsu_rdata_i : result;
	assign next_pc_valid_o = ((state_q == EXEC) && !is_mem) || mem_fin_q;

	assert property (@(posedge CLK) disable iff (!RSTn)
		lsu_done_i |-> state_q == MEM);

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
	input  logic			CLK,
	input  logic			RSTn,
	input  rv_pkg::reg_idx_t	rs1_idx_i,
	input  rv_pkg::reg_idx_t	rs2_idx_i,
	output rv_pkg::xlen_t		rs1_data_o,
	output rv_pkg::xlen_t		rs2_data_o,
	input  logic			we_i,
	input  rv_pkg::reg_idx_t	rd_idx_i,
	input  rv_pkg::xlen_t		rd_data_i
);
	import rv_pkg::*;

	xlen_t	regs [1:31];	// x0 has no storage

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we_i && rd_idx_i != 5'd0) begin
			regs[rd_idx_i] <= rd_data_i;
		end
	end

	assign rs1_data_o = (rs1_idx_i == 5'd0) ? '0 : regs[rs1_idx_i];
	assign rs2_data_o = (rs2_idx_i == 5'd0) ? '0 : regs[rs2_idx_i];

endmodule

/* hdl/rv_fetch.sv */
`timescale 1ns/100ps

module rv_fetch #(
	parameter rv_pkg::xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
	input  logic			CLK,
	input  logic			RSTn,
	input  rv_pkg::xlen_t		next_pc_i,
	input  logic			next_pc_valid_i,
	output rv_pkg::inst_t		inst_o,
	output rv_pkg::xlen_t		pc_o,
	output logic			inst_valid_o,
	output logic			ibus_cyc_o,
	output logic			ibus_stb_o,
	output rv_pkg::bus_addr_t	ibus_adr_o,
	input  rv_pkg::inst_t		ibus_dat_i,
	input  logic			ibus_ack_i
);
	import rv_pkg::*;

	xlen_t	pc_q;
	logic	boot_q;		// Kicks off the first fetch
	logic	ack;

	assign ack = ibus_stb_o && ibus_ack_i;

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			pc_q         <= RESET_PC;
			boot_q       <= 1'b1;
			ibus_cyc_o   <= 1'b0;
			ibus_stb_o   <= 1'b0;
			inst_valid_o <= 1'b0;
		end else begin
			boot_q       <= 1'b0;
			inst_valid_o <= 1'b0;
			if (boot_q || next_pc_valid_i) begin
				ibus_cyc_o <= 1'b1;
				ibus_stb_o <= 1'b1;
			end else if (ack) begin
				ibus_cyc_o   <= 1'b0;
				ibus_stb_o   <= 1'b0;
				inst_valid_o <= 1'b1;
			end
			if (next_pc_valid_i)
				pc_q <= next_pc_i;
		end
	end

	// Held until the next fetch completes
	always_ff @(posedge CLK) begin
		if (ack)
			inst_o <= ibus_dat_i;
	end

	assign pc_o       = pc_q;
	assign ibus_adr_o = pc_q[31:0];

	assert property (@(posedge CLK) disable iff (!RSTn)
		ibus_stb_o && !ibus_ack_i |=> ibus_stb_o && $stable(ibus_adr_o));

	// Target of the last branch or jump
	assert property (@(posedge CLK) disable iff (!RSTn)
		ibus_stb_o |-> pc_q[1:0] == 2'b00);

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

	parameter int XLEN = 64;

	typedef logic [XLEN-1:0]	xlen_t;
	typedef logic [31:0]		inst_t;
	typedef logic [31:0]		bus_addr_t;	// Wishbone byte address
	typedef logic [4:0]		reg_idx_t;
	typedef logic [XLEN/8-1:0]	wb_sel_t;	// One bit per data byte

	// Major opcodes kept by the core
	typedef enum logic [6:0] {
		LOAD	= 7'b00_000_11,
		STORE	= 7'b01_000_11,
		BRANCH	= 7'b11_000_11,
		JALR	= 7'b11_001_11,
		JAL	= 7'b11_011_11,
		OP_IMM	= 7'b00_100_11,
		OP	= 7'b01_100_11,
		AUIPC	= 7'b00_101_11,
		LUI	= 7'b01_101_11
	} opcode_e;

	typedef enum logic [1:0] {
		IDLE,		// Before the first instruction
		EXEC,
		MEM,		// Load or store on the data bus
		WAIT_FETCH
	} exec_state_e;

	typedef enum logic {
		WORD,
		DOUBLE
	} mem_size_e;

endpackage
